/* hdl/hdc_defs.svh */
`ifndef HDC_DEFS_SVH
`define HDC_DEFS_SVH

// Encoder dimensions
`define HV_DIM          64
`define SEQ_CYCLE_COUNT 16      // Features per encoding, also the bundle length
`define LEVEL_BITS      4
`define CTR_BITS        4
`define VOTE_BITS       5       // Must hold SEQ_CYCLE_COUNT

// Fixed item memory seeds
`define POS_SEED        64'h9E37_79B9_7F4A_7C15
`define LEVEL_SEED      64'hC2B2_AE3D_27D4_EB4F
`define LEVEL_FLIP      4       // Bits inverted per level step

// Host register map
`define ADDR_BITS       2
`define ADDR_CTRL       2'd0
`define ADDR_FEAT_LO    2'd1
`define ADDR_FEAT_HI    2'd2

`endif

/* hdl/hdc_pkg.sv */
`include "hdc_defs.svh"

package hdc_pkg;

    // Control view of a write to ADDR_CTRL
    typedef struct packed {
        logic [28:0] reserved;
        logic        tie_break;
        logic        enable;
        logic        start;       // Bit 0
    } ctrl_word_t;

    // One write word, interpreted according to the address
    typedef union packed {
        ctrl_word_t                                ctrl;
        logic [7:0][`LEVEL_BITS-1:0]               feat;    // feat[0] in the low nibble
    } reg_word_u;

    typedef enum logic [1:0] {
        S_IDLE,
        S_BIND,
        S_BUNDLE,
        S_ENC_DONE
    } enc_state_e;

endpackage

/* hdl/hdc_ctrl_if.sv */
`timescale 1ns/100ps
`include "hdc_defs.svh"

// Configuration from the register block toward the encoder core
interface hdc_ctrl_if;

    logic                  en;
    logic                  start_encoding;
    logic                  tie_break;
    logic [`HV_DIM-1:0]    features;        // Sixteen 4-bit levels, feature 0 lowest

    modport regs (
        output en,
        output start_encoding,
        output tie_break,
        output features
    );

    modport core (
        input en,
        input start_encoding,
        input tie_break,
        input features
    );

endinterface

/* hdl/hdc_regs.sv */
`timescale 1ns/100ps
`include "hdc_defs.svh"

module hdc_regs
    import hdc_pkg::*;
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  wr_strobe,
    input  logic [`ADDR_BITS-1:0] wr_addr,
    input  reg_word_u             wr_data,
    hdc_ctrl_if.regs              ctrl
);

    logic ctrl_wr;
    logic lo_wr;
    logic hi_wr;

    assign ctrl_wr = wr_strobe && (wr_addr == `ADDR_CTRL);
    assign lo_wr   = wr_strobe && (wr_addr == `ADDR_FEAT_LO);
    assign hi_wr   = wr_strobe && (wr_addr == `ADDR_FEAT_HI);

    // Sticky control bits
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ctrl.en        <= 1'b0;
            ctrl.tie_break <= 1'b0;
        end else if (ctrl_wr) begin
            ctrl.en        <= wr_data.ctrl.enable;
            ctrl.tie_break <= wr_data.ctrl.tie_break;
        end
    end

    // Start only fires when it is written together with enable
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ctrl.start_encoding <= 1'b0;
        end else begin
            ctrl.start_encoding <= ctrl_wr && wr_data.ctrl.start && wr_data.ctrl.enable;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ctrl.features <= '0;
        end else begin
            if (lo_wr) begin
                ctrl.features[`HV_DIM/2-1:0] <= wr_data.feat;       // Features 0 to 7
            end
            if (hi_wr) begin
                ctrl.features[`HV_DIM-1:`HV_DIM/2] <= wr_data.feat; // Features 8 to 15
            end
        end
    end

endmodule

/* hdl/enc_fsm.sv */
`timescale 1ns/100ps
`include "hdc_defs.svh"

module enc_fsm
    import hdc_pkg::*;
(
    input  logic                 clk,
    input  logic                 nrst,
    hdc_ctrl_if.core             ctrl,
    output logic [`CTR_BITS-1:0] ctr,
    output logic                 bundling_features,
    output logic                 encoding_done
);

    enc_state_e state;
    logic       bundling_done;
    logic       go;

    assign go            = ctrl.start_encoding && ctrl.en;
    assign bundling_done = (ctr == `CTR_BITS'(`SEQ_CYCLE_COUNT - 1));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_BIND:   state <= S_BUNDLE;
                S_BUNDLE: state <= bundling_done ? S_ENC_DONE : S_BUNDLE;
                // A start in the done state chains straight into a new bind
                default:  state <= go ? S_BIND : S_IDLE;
            endcase
        end
    end

    // Moore outputs
    always_comb begin
        case (state)
            S_BUNDLE:   {bundling_features, encoding_done} = 2'b10;
            S_ENC_DONE: {bundling_features, encoding_done} = 2'b01;
            default:    {bundling_features, encoding_done} = 2'b00;
        endcase
    end

    // Feature select, wraps back to zero on the last bundle cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ctr <= '0;
        end else if ((state == S_BUNDLE) && ctrl.en) begin
            ctr <= ctr + 1'b1;
        end else begin
            ctr <= '0;
        end
    end

endmodule

/* hdl/bind_unit.sv */
`timescale 1ns/100ps
`include "hdc_defs.svh"

module bind_unit (
    hdc_ctrl_if.core              ctrl,
    input  logic [`CTR_BITS-1:0]  ctr,
    output logic [`HV_DIM-1:0]    bound_hv
);

    logic [`LEVEL_BITS-1:0] level;
    logic [2*`HV_DIM-1:0]   pos_dbl;
    logic [`HV_DIM-1:0]     pos_hv;
    logic [`HV_DIM-1:0]     flip_mask;
    logic [`HV_DIM-1:0]     level_hv;

    // Current feature out of the packed store
    assign level = ctrl.features[ctr*`LEVEL_BITS +: `LEVEL_BITS];

    // Rotate left by the feature index using a doubled copy of the seed
    assign pos_dbl = {`POS_SEED, `POS_SEED} << ctr;
    assign pos_hv  = pos_dbl[2*`HV_DIM-1:`HV_DIM];

    // Each level step inverts LEVEL_FLIP more low bits of the level seed
    assign flip_mask = ~({`HV_DIM{1'b1}} << (level * `LEVEL_FLIP));
    assign level_hv  = `LEVEL_SEED ^ flip_mask;

    assign bound_hv = pos_hv ^ level_hv;    // Binding is a plain XOR

endmodule

/* hdl/bundler.sv */
`timescale 1ns/100ps
`include "hdc_defs.svh"

module bundler (
    input  logic                 clk,
    input  logic                 nrst,
    hdc_ctrl_if.core             ctrl,
    input  logic                 bundling_features,
    input  logic [`CTR_BITS-1:0] ctr,
    input  logic [`HV_DIM-1:0]   bound_hv,
    output logic [`HV_DIM-1:0]   hv
);

    localparam int unsigned HALF = `SEQ_CYCLE_COUNT / 2;

    logic [`HV_DIM-1:0][`VOTE_BITS-1:0] votes;

    // One vote counter per hypervector bit
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            votes <= '0;
        end else if (bundling_features) begin
            for (int i = 0; i < `HV_DIM; i++) begin
                if (ctr == '0) begin
                    // First bundle cycle restarts the count with this vote
                    votes[i] <= {{(`VOTE_BITS-1){1'b0}}, bound_hv[i]};
                end else begin
                    votes[i] <= votes[i] + {{(`VOTE_BITS-1){1'b0}}, bound_hv[i]};
                end
            end
        end
    end

    // Majority threshold
    always_comb begin
        for (int i = 0; i < `HV_DIM; i++) begin
            if (votes[i] > HALF) begin
                hv[i] = 1'b1;
            end else if (votes[i] == HALF) begin
                hv[i] = ctrl.tie_break;     // Exact tie
            end else begin
                hv[i] = 1'b0;
            end
        end
    end

endmodule

/* hdl/hdc_encoder_top.sv */
`timescale 1ns/100ps
`include "hdc_defs.svh"

module hdc_encoder_top (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  wr_strobe,
    input  logic [`ADDR_BITS-1:0] wr_addr,
    input  logic [31:0]           wr_data,
    output logic [`HV_DIM-1:0]    hv_out,
    output logic                  encoding_done
);

    logic [`CTR_BITS-1:0] ctr;
    logic                 bundling_features;
    logic [`HV_DIM-1:0]   bound_hv;

    hdc_ctrl_if u_ctrl_if ();

    hdc_regs u_hdc_regs (
        .clk       (clk),
        .nrst      (nrst),
        .wr_strobe (wr_strobe),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .ctrl      (u_ctrl_if.regs)
    );

    enc_fsm u_enc_fsm (
        .clk               (clk),
        .nrst              (nrst),
        .ctrl              (u_ctrl_if.core),
        .ctr               (ctr),
        .bundling_features (bundling_features),
        .encoding_done     (encoding_done)
    );

    bind_unit u_bind_unit (
        .ctrl     (u_ctrl_if.core),
        .ctr      (ctr),
        .bound_hv (bound_hv)
    );

    bundler u_bundler (
        .clk               (clk),
        .nrst              (nrst),
        .ctrl              (u_ctrl_if.core),
        .bundling_features (bundling_features),
        .ctr               (ctr),
        .bound_hv          (bound_hv),
        .hv                (hv_out)
    );

endmodule

/* verif/hdc_encoder_checker.sv */
`timescale 1ns/100ps
`include "hdc_defs.svh"

module hdc_encoder_checker
    import hdc_pkg::*;
(
    input logic                 clk,
    input logic                 nrst,
    input enc_state_e           state,
    input logic [`CTR_BITS-1:0] ctr,
    input logic                 bundling_features,
    input logic                 encoding_done
);

    done_single_cycle: assert property (@(posedge clk) disable iff (!nrst)
        encoding_done |=> !encoding_done)
        else $error("encoding_done held for more than one cycle");

    // Moore outputs are exclusive
    bundle_done_exclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(bundling_features && encoding_done))
        else $error("bundling_features and encoding_done high together");

    ctr_idle_zero: assert property (@(posedge clk) disable iff (!nrst)
        (state != S_BUNDLE) |-> (ctr == '0))
        else $error("ctr nonzero outside S_BUNDLE");

    bind_to_bundle: assert property (@(posedge clk) disable iff (!nrst)
        (state == S_BIND) |=> (state == S_BUNDLE))
        else $error("S_BIND not followed by S_BUNDLE");

endmodule

bind enc_fsm hdc_encoder_checker u_hdc_encoder_checker (
    .clk               (clk),
    .nrst              (nrst),
    .state             (state),
    .ctr               (ctr),
    .bundling_features (bundling_features),
    .encoding_done     (encoding_done)
);

/* verif/tb_hdc_encoder.sv */
`timescale 1ns/100ps
`include "hdc_defs.svh"

module tb_hdc_encoder
    import hdc_pkg::*;
();

    localparam int LATENCY = `SEQ_CYCLE_COUNT + 2;  // Start write edge to done
    localparam int TIMEOUT = 100;

    logic                  clk;
    logic                  nrst;
    logic                  wr_strobe;
    logic [`ADDR_BITS-1:0] wr_addr;
    logic [31:0]           wr_data;
    logic [`HV_DIM-1:0]    hv_out;
    logic                  encoding_done;

    integer             seed;
    int                 errors;
    int                 checks;
    string              test_name;
    logic [`HV_DIM-1:0] exp_hv;

    hdc_encoder_top u_hdc_encoder_top (
        .clk           (clk),
        .nrst          (nrst),
        .wr_strobe     (wr_strobe),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .hv_out        (hv_out),
        .encoding_done (encoding_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Bound vector of feature f, built bit by bit from the seeds
    function automatic logic [`HV_DIM-1:0] bound_ref(input logic [`HV_DIM-1:0] feats,
                                                     input int f);
        logic [`HV_DIM-1:0] pos_seed;
        logic [`HV_DIM-1:0] lvl_seed;
        logic [`HV_DIM-1:0] bv;
        int                 lvl;
        pos_seed = `POS_SEED;
        lvl_seed = `LEVEL_SEED;
        lvl      = int'(feats[f*`LEVEL_BITS +: `LEVEL_BITS]);
        for (int b = 0; b < `HV_DIM; b++) begin
            // Rotating left by f moves seed bit b-f up to bit b
            bv[b] = pos_seed[(b - f + `HV_DIM) % `HV_DIM] ^ lvl_seed[b]
                    ^ (b < lvl * `LEVEL_FLIP);
        end
        return bv;
    endfunction

    function automatic int vote_count(input logic [`HV_DIM-1:0] feats, input int b);
        logic [`HV_DIM-1:0] bv;
        int                 votes;
        votes = 0;
        for (int f = 0; f < `SEQ_CYCLE_COUNT; f++) begin
            bv = bound_ref(feats, f);
            votes += int'(bv[b]);
        end
        return votes;
    endfunction

    function automatic logic [`HV_DIM-1:0] encode_ref(input logic [`HV_DIM-1:0] feats,
                                                      input logic tie);
        logic [`HV_DIM-1:0] res;
        int                 votes;
        for (int b = 0; b < `HV_DIM; b++) begin
            votes  = vote_count(feats, b);
            res[b] = (votes > `SEQ_CYCLE_COUNT / 2)
                     || ((votes == `SEQ_CYCLE_COUNT / 2) && tie);
        end
        return res;
    endfunction

    // Bits whose vote is exactly half
    function automatic logic [`HV_DIM-1:0] tie_mask(input logic [`HV_DIM-1:0] feats);
        logic [`HV_DIM-1:0] res;
        for (int b = 0; b < `HV_DIM; b++) begin
            res[b] = (vote_count(feats, b) == `SEQ_CYCLE_COUNT / 2);
        end
        return res;
    endfunction

    function automatic reg_word_u ctrl_word(input logic start, input logic enable,
                                            input logic tie);
        reg_word_u w;
        w                = '0;
        w.ctrl.start     = start;
        w.ctrl.enable    = enable;
        w.ctrl.tie_break = tie;
        return w;
    endfunction

    task automatic write_reg(input logic [`ADDR_BITS-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        wr_strobe <= 1'b1;
        wr_addr   <= addr;
        wr_data   <= data;
        @(posedge clk);             // This edge samples the write
        wr_strobe <= 1'b0;
    endtask

    task automatic load_features(input logic [`HV_DIM-1:0] feats);
        reg_word_u lo;
        reg_word_u hi;
        for (int j = 0; j < 8; j++) begin
            lo.feat[j] = feats[j*`LEVEL_BITS +: `LEVEL_BITS];
            hi.feat[j] = feats[(j+8)*`LEVEL_BITS +: `LEVEL_BITS];
        end
        write_reg(`ADDR_FEAT_LO, lo);
        write_reg(`ADDR_FEAT_HI, hi);
    endtask

    task automatic compare_hv(input string name, input logic [`HV_DIM-1:0] exp,
                              input logic [`HV_DIM-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Loads features, starts, and waits for done while counting the latency
    task automatic run_encoding(input string name, input logic [`HV_DIM-1:0] feats,
                                input logic tie);
        int n;
        load_features(feats);
        test_name = name;
        exp_hv    = encode_ref(feats, tie);
        write_reg(`ADDR_CTRL, ctrl_word(1'b1, 1'b1, tie));
        @(negedge clk);             // Still in the cycle of the sampling edge
        n = 0;
        while (!encoding_done && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (!encoding_done) begin
            errors++;
            $display("Timeout in %s: encoding_done never came after the start write", name);
        end else if (n != LATENCY) begin
            errors++;
            $display("ERR %s latency: expected %0d, actual %0d", name, LATENCY, n);
        end
        @(negedge clk);
        if (encoding_done) begin
            errors++;
            $display("Error in %s: encoding_done stayed high for more than one cycle", name);
        end
    endtask

    // Result check on every done pulse
    always @(negedge clk) begin
        if (nrst && encoding_done) begin
            compare_hv(test_name, exp_hv, hv_out);
        end
    end

    initial begin
        logic [`HV_DIM-1:0] feats;
        logic [`HV_DIM-1:0] hv_a;
        logic [`HV_DIM-1:0] last_hv;
        logic [31:0]        rnd;
        int                 n;
        seed      = 11516;
        errors    = 0;
        checks    = 0;
        test_name = "reset";
        exp_hv    = '0;
        nrst      = 1'b0;
        wr_strobe = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        repeat (3) @(posedge clk);
        nrst <= 1'b1;

        n = 0;
        while (n < 10) begin
            @(negedge clk);
            n++;
            compare_hv("reset_hv", '0, hv_out);
            if (encoding_done) begin
                errors++;
                $display("Error in reset: encoding_done rose without a start");
            end
        end

        for (int i = 0; i < 20; i++) begin
            feats = {$random(seed), $random(seed)};
            rnd   = $random(seed);
            run_encoding($sformatf("random_%0d", i), feats, rnd[0]);
        end

        feats = {$random(seed), $random(seed)};
        run_encoding("tie_break_0", feats, 1'b0);
        hv_a = hv_out;
        run_encoding("tie_break_1", feats, 1'b1);
        compare_hv("tie_break_diff", tie_mask(feats), hv_a ^ hv_out);

        last_hv = hv_out;
        n = 0;
        while (n < 10) begin
            @(negedge clk);
            n++;
            compare_hv("hold", last_hv, hv_out);
        end

        // Same tie_break as the last run, so hv_out must not move
        write_reg(`ADDR_CTRL, ctrl_word(1'b1, 1'b0, 1'b1));
        n = 0;
        while (n < 40) begin
            @(negedge clk);
            n++;
            if (encoding_done) begin
                errors++;
                $display("Error in enable_gate: encoding_done rose with enable clear");
            end
        end
        compare_hv("enable_gate_hold", last_hv, hv_out);

        feats = {$random(seed), $random(seed)};
        rnd   = $random(seed);
        run_encoding("back_to_back", feats, rnd[0]);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+hdl
hdl/hdc_pkg.sv
hdl/hdc_ctrl_if.sv
hdl/hdc_regs.sv
hdl/enc_fsm.sv
hdl/bind_unit.sv
hdl/bundler.sv
hdl/hdc_encoder_top.sv
verif/hdc_encoder_checker.sv
verif/tb_hdc_encoder.sv

/* Makefile */
TOP = tb_hdc_encoder

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

clean:
	rm -rf obj_dir
